// File: src.f
+incdir+rtl
rtl/sb_pkg.sv
rtl/sb_reg_status.sv
rtl/sb_dispatch.sv
rtl/sb_issue.sv
rtl/sb_top.sv
tb/sb_checker.sv
tb/tb_scoreboard.sv

// File: tb/tb_scoreboard.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module tb_scoreboard;

    localparam int NUM_RANDOM  = 200;
    // longest wait for one fetch, drain or halt step, in cycles
    localparam int STALL_LIMIT = 64;
    // every instruction and every drain may take up to STALL_LIMIT cycles of 4 ns
    localparam int TEST_CYCLES = (NUM_RANDOM + 10) * STALL_LIMIT + 6 * STALL_LIMIT;
    localparam int WATCHDOG_NS = TEST_CYCLES * 4 + 1000;

    logic                  CLK;
    logic                  rst_n;
    logic                  fetch_valid;
    sb_pkg::fu_kind_t      fetch_kind;
    logic [`SB_REG_W-1:0]  fetch_rd;
    logic [`SB_REG_W-1:0]  fetch_rs1;
    logic [`SB_REG_W-1:0]  fetch_rs2;
    logic [`SB_NUM_FU-1:0] fu_done;
    logic                  branch_resolved;
    logic                  freeze;
    logic                  jump;
    logic                  fetch_halt;
    logic                  halt;
    logic                  out_valid;
    sb_pkg::fu_id_t        out_fu;
    logic [`SB_REG_W-1:0]  out_rd;
    logic [`SB_REG_W-1:0]  out_rs1;
    logic [`SB_REG_W-1:0]  out_rs2;

    // cycles left until each unit reports completion, 0 when idle
    int countdown [`SB_NUM_FU];

    sb_top u_sb_top (.*);

    sb_checker u_chk (.*);

    initial CLK = 1'b0;
    always #2 CLK = ~CLK;

    function automatic bit units_in_flight();
        for (int u = 0; u < `SB_NUM_FU; u++) begin
            if (countdown[u] != 0) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // plays execute where a unit finishes 1 to 6 cycles after its out_valid
    task automatic execute_step();
        fu_done = '0;
        branch_resolved = 1'b0;
        for (int u = 0; u < `SB_NUM_FU; u++) begin
            if (countdown[u] == 1) begin
                fu_done[u] = 1'b1;
                branch_resolved = branch_resolved || (u == sb_pkg::FU_BR);
            end
            if (countdown[u] > 0) begin
                countdown[u]--;
            end
        end
        if (out_valid) begin
            countdown[out_fu] = 1 + $urandom % 6;
        end
    endtask

    always begin
        @(posedge CLK);
        #0.5;
        if (rst_n) begin
            execute_step();
        end
    end

    task automatic go_idle();
        fetch_valid = 1'b0;
        fetch_kind  = sb_pkg::KIND_ALU;
        fetch_rd    = '0;
        fetch_rs1   = '0;
        fetch_rs2   = '0;
    endtask

    // present one instruction and hold it until dispatch takes it
    task automatic send(input sb_pkg::fu_kind_t kind, input int rd, input int rs1, input int rs2);
        bit taken;
        int waited;
        taken = 1'b0;
        waited = 0;
        fetch_valid = 1'b1;
        fetch_kind  = kind;
        fetch_rd    = rd[`SB_REG_W-1:0];
        fetch_rs1   = rs1[`SB_REG_W-1:0];
        fetch_rs2   = rs2[`SB_REG_W-1:0];
        while (!taken && waited < STALL_LIMIT) begin
            #1;
            taken = !freeze;
            @(posedge CLK);
            #0.5;
            waited++;
        end
        if (!taken) begin
            u_chk.note_failure($sformatf("fetch held for %0d cycles without accept", waited));
        end
        go_idle();
    endtask

    // wait until nothing is issued or in flight for three cycles
    task automatic drain();
        int quiet;
        int waited;
        quiet = 0;
        waited = 0;
        while (quiet < 3 && waited < STALL_LIMIT) begin
            @(posedge CLK);
            #1.5;
            waited++;
            quiet = (out_valid || units_in_flight()) ? 0 : quiet + 1;
        end
        if (quiet < 3) begin
            u_chk.note_failure("units did not drain");
        end
        @(posedge CLK);
        #0.5;
    endtask

    task automatic wait_for_halt();
        int waited;
        waited = 0;
        while (!halt && waited < STALL_LIMIT) begin
            @(posedge CLK);
            #0.5;
            waited++;
        end
        if (!halt) begin
            u_chk.note_failure("halt never rose after the HALT instruction");
        end
        repeat (2) @(posedge CLK);
    endtask

    initial begin
        void'($urandom(32'hd2ec2e15));
        rst_n = 1'b0;
        fu_done = '0;
        branch_resolved = 1'b0;
        go_idle();
        repeat (2) @(posedge CLK);
        #0.5;
        rst_n = 1'b1;

        send(sb_pkg::KIND_ALU, 1, 2, 3);
        drain();
        u_chk.end_test("independent alu");

        // lsu reads x5 written by the alu
        send(sb_pkg::KIND_ALU, 5, 1, 2);
        send(sb_pkg::KIND_LSU, 6, 5, 0);
        drain();
        u_chk.end_test("raw alu to lsu");

        send(sb_pkg::KIND_ALU, 7, 1, 2);
        send(sb_pkg::KIND_ALU, 8, 7, 0);
        send(sb_pkg::KIND_LSU, 8, 3, 4);
        drain();
        u_chk.end_test("structural and waw");

        send(sb_pkg::KIND_BR, 0, 8, 9);
        send(sb_pkg::KIND_ALU, 9, 8, 0);
        drain();
        u_chk.end_test("branch");

        repeat (NUM_RANDOM) begin
            send(sb_pkg::fu_kind_t'($urandom % 3), $urandom % 32, $urandom % 32,
                 $urandom % 32);
        end
        drain();
        u_chk.end_test("random stream");

        send(sb_pkg::KIND_ALU, 10, 9, 0);
        send(sb_pkg::KIND_HALT, 0, 0, 0);
        wait_for_halt();
        u_chk.end_test("halt");

        u_chk.report_counts();
        if (u_chk.total_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #WATCHDOG_NS;
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: tb/sb_checker.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module sb_checker (
    input logic                  CLK,
    input logic                  rst_n,
    input logic                  fetch_valid,
    input sb_pkg::fu_kind_t      fetch_kind,
    input logic [`SB_REG_W-1:0]  fetch_rd,
    input logic [`SB_REG_W-1:0]  fetch_rs1,
    input logic [`SB_REG_W-1:0]  fetch_rs2,
    input logic [`SB_NUM_FU-1:0] fu_done,
    input logic                  branch_resolved,
    input logic                  freeze,
    input logic                  jump,
    input logic                  fetch_halt,
    input logic                  halt,
    input logic                  out_valid,
    input sb_pkg::fu_id_t        out_fu,
    input logic [`SB_REG_W-1:0]  out_rd,
    input logic [`SB_REG_W-1:0]  out_rs1,
    input logic [`SB_REG_W-1:0]  out_rs2
);

    // shadow scoreboard that keeps each tag as a unit number or -1
    int reg_owner [`SB_NUM_REGS];
    int src1 [`SB_NUM_FU];
    int src2 [`SB_NUM_FU];
    int fld_rd [`SB_NUM_FU];
    int fld_rs1 [`SB_NUM_FU];
    int fld_rs2 [`SB_NUM_FU];
    logic [`SB_NUM_FU-1:0] busy;
    logic [`SB_NUM_FU-1:0] sent;
    logic m_valid;
    logic m_jump;
    logic m_br;
    logic m_fhalt;
    logic m_halt;
    logic armed = 1'b0;
    int m_fu;
    int m_rd;
    int m_rs1;
    int m_rs2;

    int total_errors = 0;
    int test_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    // lowest numbered ready unit goes first, -1 when none is ready
    function automatic int expected_issue(input logic [`SB_NUM_FU-1:0] busy_v,
                                          input logic [`SB_NUM_FU-1:0] sent_v,
                                          input logic [`SB_NUM_FU-1:0] blocked_v);
        for (int u = 0; u < `SB_NUM_FU; u++) begin
            if (busy_v[u] && !sent_v[u] && !blocked_v[u]) begin
                return u;
            end
        end
        return -1;
    endfunction

    function automatic int unit_of(input sb_pkg::fu_kind_t kind);
        case (kind)
            sb_pkg::KIND_LSU: return 1;
            sb_pkg::KIND_BR:  return 2;
            default:          return 0;
        endcase
    endfunction

    function automatic int woken(input int owner, input logic [`SB_NUM_FU-1:0] done);
        if (owner >= 0 && done[owner]) begin
            return -1;
        end
        return owner;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] t=%0t %s expected %0d got %0d", $time, name, exp, act);
            total_errors++;
            test_errors++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("t=%0t: %s", $time, msg);
        total_errors++;
        test_errors++;
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic report_counts();
        $display("tests ok: %0d, tests with errors: %0d, errors: %0d",
                 tests_passed, tests_failed, total_errors);
    endtask

    task automatic reset_model();
        for (int r = 0; r < `SB_NUM_REGS; r++) begin
            reg_owner[r] = -1;
        end
        for (int u = 0; u < `SB_NUM_FU; u++) begin
            src1[u] = -1;
            src2[u] = -1;
        end
        busy = '0;
        sent = '0;
        m_valid = 1'b0;
        m_jump = 1'b0;
        m_br = 1'b0;
        m_fhalt = 1'b0;
        m_halt = 1'b0;
    endtask

    // outputs and inputs are both settled half a cycle after the edge
    always @(negedge CLK) begin : model
        logic exp_freeze;
        logic accept;
        logic alloc;
        logic [`SB_NUM_FU-1:0] blocked;
        int ufu;
        int sel;
        int look1;
        int look2;
        if (!rst_n) begin
            reset_model();
            armed = 1'b1;
        end else if (armed) begin
            ufu = unit_of(fetch_kind);
            exp_freeze = (fetch_valid && fetch_kind != sb_pkg::KIND_HALT && busy[ufu])
                || reg_owner[fetch_rd] >= 0 || m_br || m_fhalt;
            compare("freeze", exp_freeze, freeze);
            compare("out_valid", m_valid, out_valid);
            if (m_valid) begin
                compare("out_fu", m_fu, out_fu);
                compare("out_rd", m_rd, out_rd);
                compare("out_rs1", m_rs1, out_rs1);
                compare("out_rs2", m_rs2, out_rs2);
            end
            compare("jump", m_jump, jump);
            compare("fetch_halt", m_fhalt, fetch_halt);
            compare("halt", m_halt, halt);

            // state after the coming edge
            accept = fetch_valid && !exp_freeze;
            alloc = accept && fetch_kind != sb_pkg::KIND_HALT;
            for (int u = 0; u < `SB_NUM_FU; u++) begin
                blocked[u] = src1[u] >= 0 || src2[u] >= 0;
            end
            sel = expected_issue(busy, sent, blocked);
            look1 = woken(reg_owner[fetch_rs1], fu_done);
            look2 = woken(reg_owner[fetch_rs2], fu_done);
            if (m_fhalt && busy == '0) begin
                m_halt = 1'b1;
            end
            m_jump = accept && fetch_kind == sb_pkg::KIND_BR;
            if (m_jump) begin
                m_br = 1'b1;
            end else if (branch_resolved) begin
                m_br = 1'b0;
            end
            if (accept && fetch_kind == sb_pkg::KIND_HALT) begin
                m_fhalt = 1'b1;
            end
            m_valid = sel >= 0;
            if (m_valid) begin
                m_fu = sel;
                m_rd = fld_rd[sel];
                m_rs1 = fld_rs1[sel];
                m_rs2 = fld_rs2[sel];
            end
            for (int u = 0; u < `SB_NUM_FU; u++) begin
                if (alloc && ufu == u) begin
                    busy[u] = 1'b1;
                    sent[u] = 1'b0;
                    src1[u] = look1;
                    src2[u] = look2;
                    fld_rd[u] = fetch_rd;
                    fld_rs1[u] = fetch_rs1;
                    fld_rs2[u] = fetch_rs2;
                end else begin
                    if (fu_done[u]) begin
                        busy[u] = 1'b0;
                        sent[u] = 1'b0;
                    end else if (sel == u) begin
                        sent[u] = 1'b1;
                    end
                    src1[u] = woken(src1[u], fu_done);
                    src2[u] = woken(src2[u], fu_done);
                end
            end
            // x0 never gets a writer
            for (int r = 1; r < `SB_NUM_REGS; r++) begin
                if (alloc && fetch_rd == r) begin
                    reg_owner[r] = ufu;
                end else begin
                    reg_owner[r] = woken(reg_owner[r], fu_done);
                end
            end
        end
    end

endmodule

// File: rtl/sb_top.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module sb_top (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   fetch_valid,
    input  sb_pkg::fu_kind_t       fetch_kind,
    input  logic [`SB_REG_W-1:0]   fetch_rd,
    input  logic [`SB_REG_W-1:0]   fetch_rs1,
    input  logic [`SB_REG_W-1:0]   fetch_rs2,
    input  logic [`SB_NUM_FU-1:0]  fu_done,
    input  logic                   branch_resolved,
    output logic                   freeze,
    output logic                   jump,
    output logic                   fetch_halt,
    output logic                   halt,
    output logic                   out_valid,
    output sb_pkg::fu_id_t         out_fu,
    output logic [`SB_REG_W-1:0]   out_rd,
    output logic [`SB_REG_W-1:0]   out_rs1,
    output logic [`SB_REG_W-1:0]   out_rs2
);

    // register lookups for the fetched instruction
    sb_pkg::tag_t          rs1_tag;
    sb_pkg::tag_t          rs2_tag;
    sb_pkg::tag_t          rd_tag;

    // allocation from dispatch into both tables
    logic                  alloc_en;
    sb_pkg::fu_id_t        alloc_fu;
    logic [`SB_REG_W-1:0]  alloc_rd;
    logic [`SB_REG_W-1:0]  alloc_rs1;
    logic [`SB_REG_W-1:0]  alloc_rs2;
    sb_pkg::tag_t          alloc_t1;
    sb_pkg::tag_t          alloc_t2;

    logic [`SB_NUM_FU-1:0] fu_busy;

    sb_reg_status u_reg_status (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .rs1      (fetch_rs1),
        .rs2      (fetch_rs2),
        .rd       (fetch_rd),
        .alloc_en (alloc_en),
        .alloc_fu (alloc_fu),
        .alloc_rd (alloc_rd),
        .fu_done  (fu_done),
        .rs1_tag  (rs1_tag),
        .rs2_tag  (rs2_tag),
        .rd_tag   (rd_tag)
    );

    sb_dispatch u_dispatch (
        .CLK             (CLK),
        .rst_n           (rst_n),
        .fetch_valid     (fetch_valid),
        .fetch_kind      (fetch_kind),
        .fetch_rd        (fetch_rd),
        .fetch_rs1       (fetch_rs1),
        .fetch_rs2       (fetch_rs2),
        .rs1_tag         (rs1_tag),
        .rs2_tag         (rs2_tag),
        .rd_tag          (rd_tag),
        .fu_busy         (fu_busy),
        .branch_resolved (branch_resolved),
        .alloc_en        (alloc_en),
        .alloc_fu        (alloc_fu),
        .alloc_rd        (alloc_rd),
        .alloc_rs1       (alloc_rs1),
        .alloc_rs2       (alloc_rs2),
        .alloc_t1        (alloc_t1),
        .alloc_t2        (alloc_t2),
        .freeze          (freeze),
        .jump            (jump),
        .fetch_halt      (fetch_halt),
        .halt            (halt)
    );

    // issue sits behind dispatch and drives execute
    sb_issue u_issue (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .alloc_en  (alloc_en),
        .alloc_fu  (alloc_fu),
        .alloc_rd  (alloc_rd),
        .alloc_rs1 (alloc_rs1),
        .alloc_rs2 (alloc_rs2),
        .alloc_t1  (alloc_t1),
        .alloc_t2  (alloc_t2),
        .fu_done   (fu_done),
        .fu_busy   (fu_busy),
        .out_valid (out_valid),
        .out_fu    (out_fu),
        .out_rd    (out_rd),
        .out_rs1   (out_rs1),
        .out_rs2   (out_rs2)
    );

endmodule

// File: rtl/sb_issue.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module sb_issue (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   alloc_en,
    input  sb_pkg::fu_id_t         alloc_fu,
    input  logic [`SB_REG_W-1:0]   alloc_rd,
    input  logic [`SB_REG_W-1:0]   alloc_rs1,
    input  logic [`SB_REG_W-1:0]   alloc_rs2,
    input  sb_pkg::tag_t           alloc_t1,
    input  sb_pkg::tag_t           alloc_t2,
    input  logic [`SB_NUM_FU-1:0]  fu_done,
    output logic [`SB_NUM_FU-1:0]  fu_busy,
    output logic                   out_valid,
    output sb_pkg::fu_id_t         out_fu,
    output logic [`SB_REG_W-1:0]   out_rd,
    output logic [`SB_REG_W-1:0]   out_rs1,
    output logic [`SB_REG_W-1:0]   out_rs2
);

    // unit status table
    logic [`SB_NUM_FU-1:0] issued;
    logic [`SB_REG_W-1:0]  rd_q  [`SB_NUM_FU];
    logic [`SB_REG_W-1:0]  rs1_q [`SB_NUM_FU];
    logic [`SB_REG_W-1:0]  rs2_q [`SB_NUM_FU];
    sb_pkg::tag_t          t1    [`SB_NUM_FU];
    sb_pkg::tag_t          t2    [`SB_NUM_FU];

    logic [`SB_NUM_FU-1:0] ready;
    logic                  sel_any;
    sb_pkg::fu_id_t        sel_fu;

    // drop the wait if the producing unit finishes this cycle
    function automatic sb_pkg::tag_t wake(input sb_pkg::tag_t t,
                                          input logic [`SB_NUM_FU-1:0] done);
        sb_pkg::tag_t res;
        res = t;
        if (t.valid && done[t.fu]) begin
            res.valid = 1'b0;
        end
        return res;
    endfunction

    always_comb begin
        for (int u = 0; u < `SB_NUM_FU; u++) begin
            ready[u] = fu_busy[u] && !issued[u] && !t1[u].valid && !t2[u].valid;
        end
    end

    // fixed priority where the lowest index wins (ALU, LSU, BR)
    always_comb begin
        sel_any = 1'b0;
        sel_fu  = sb_pkg::FU_ALU;
        for (int u = `SB_NUM_FU - 1; u >= 0; u--) begin
            if (ready[u]) begin
                sel_any = 1'b1;
                sel_fu  = sb_pkg::fu_id_t'(u);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            fu_busy   <= '0;
            issued    <= '0;
            out_valid <= 1'b0;
            for (int u = 0; u < `SB_NUM_FU; u++) begin
                t1[u] <= sb_pkg::TAG_NONE;
                t2[u] <= sb_pkg::TAG_NONE;
            end
        end else begin
            for (int u = 0; u < `SB_NUM_FU; u++) begin
                if (alloc_en && alloc_fu == sb_pkg::fu_id_t'(u)) begin
                    fu_busy[u] <= 1'b1;
                    issued[u]  <= 1'b0;
                    t1[u]      <= wake(alloc_t1, fu_done);
                    t2[u]      <= wake(alloc_t2, fu_done);
                end else begin
                    if (fu_done[u]) begin
                        fu_busy[u] <= 1'b0;
                        issued[u]  <= 1'b0;
                    end else if (sel_any && sel_fu == sb_pkg::fu_id_t'(u)) begin
                        issued[u] <= 1'b1;
                    end
                    t1[u] <= wake(t1[u], fu_done);
                    t2[u] <= wake(t2[u], fu_done);
                end
            end
            out_valid <= sel_any;
        end
    end

    // register fields and the outgoing instruction
    always_ff @(posedge CLK) begin
        for (int u = 0; u < `SB_NUM_FU; u++) begin
            if (alloc_en && alloc_fu == sb_pkg::fu_id_t'(u)) begin
                rd_q[u]  <= alloc_rd;
                rs1_q[u] <= alloc_rs1;
                rs2_q[u] <= alloc_rs2;
            end
        end
        if (sel_any) begin
            out_fu  <= sel_fu;
            out_rd  <= rd_q[sel_fu];
            out_rs1 <= rs1_q[sel_fu];
            out_rs2 <= rs2_q[sel_fu];
        end
    end

    // execute only completes work that was sent to it
    a_done_after_issue: assert property (
        @(posedge CLK) disable iff (!rst_n)
        (fu_done & ~(fu_busy & issued)) == '0
    ) else $error("fu_done %b for a unit not in flight", fu_done);

    a_issue_operands_ready: assert property (
        @(posedge CLK) disable iff (!rst_n)
        out_valid |-> (!t1[out_fu].valid && !t2[out_fu].valid)
    ) else $error("unit %0d issued with an operand still pending", out_fu);

endmodule

// File: rtl/sb_dispatch.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module sb_dispatch (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   fetch_valid,
    input  sb_pkg::fu_kind_t       fetch_kind,
    input  logic [`SB_REG_W-1:0]   fetch_rd,
    input  logic [`SB_REG_W-1:0]   fetch_rs1,
    input  logic [`SB_REG_W-1:0]   fetch_rs2,
    input  sb_pkg::tag_t           rs1_tag,
    input  sb_pkg::tag_t           rs2_tag,
    input  sb_pkg::tag_t           rd_tag,
    input  logic [`SB_NUM_FU-1:0]  fu_busy,
    input  logic                   branch_resolved,
    output logic                   alloc_en,
    output sb_pkg::fu_id_t         alloc_fu,
    output logic [`SB_REG_W-1:0]   alloc_rd,
    output logic [`SB_REG_W-1:0]   alloc_rs1,
    output logic [`SB_REG_W-1:0]   alloc_rs2,
    output sb_pkg::tag_t           alloc_t1,
    output sb_pkg::tag_t           alloc_t2,
    output logic                   freeze,
    output logic                   jump,
    output logic                   fetch_halt,
    output logic                   halt
);

    sb_pkg::fu_id_t fu;
    logic           is_halt;
    logic           is_br;
    logic           struct_haz;
    logic           waw_haz;
    logic           accept;
    logic           br_pending;

    assign fu      = sb_pkg::kind_to_fu(fetch_kind);
    assign is_halt = (fetch_kind == sb_pkg::KIND_HALT);
    assign is_br   = (fetch_kind == sb_pkg::KIND_BR);

    // HALT needs no unit, so it never waits on a busy one
    assign struct_haz = fetch_valid && !is_halt && fu_busy[fu];

    // the destination still has an older writer in flight
    assign waw_haz = rd_tag.valid;

    // a pending branch or a halt stops everything behind it
    assign freeze = struct_haz || waw_haz || br_pending || fetch_halt;

    assign accept   = fetch_valid && !freeze;
    assign alloc_en = accept && !is_halt;

    // fields handed to the status table and the unit table
    assign alloc_fu  = fu;
    assign alloc_rd  = fetch_rd;
    assign alloc_rs1 = fetch_rs1;
    assign alloc_rs2 = fetch_rs2;
    assign alloc_t1  = rs1_tag;
    assign alloc_t2  = rs2_tag;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            br_pending <= 1'b0;
            jump       <= 1'b0;
            fetch_halt <= 1'b0;
            halt       <= 1'b0;
        end else begin
            // one pulse per accepted branch
            jump <= accept && is_br;

            if (accept && is_br) begin
                br_pending <= 1'b1;
            end else if (branch_resolved) begin
                br_pending <= 1'b0;
            end

            // sticky until reset
            if (accept && is_halt) begin
                fetch_halt <= 1'b1;
            end

            // wait for every unit to drain before the core stops
            if (fetch_halt && fu_busy == '0) begin
                halt <= 1'b1;
            end
        end
    end

    // fetch keeps a frozen instruction in place until dispatch takes it
    a_hold_on_freeze: assert property (
        @(posedge CLK) disable iff (!rst_n)
        (fetch_valid && freeze) |=> (fetch_valid && $stable(fetch_kind) && $stable(fetch_rd)
            && $stable(fetch_rs1) && $stable(fetch_rs2))
    ) else $error("fetch changed an instruction while it was frozen");

    // execute may only resolve a branch that dispatch sent out
    a_resolve_needs_branch: assert property (
        @(posedge CLK) disable iff (!rst_n)
        branch_resolved |-> br_pending
    ) else $error("branch_resolved without a pending branch");

endmodule

// File: rtl/sb_reg_status.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module sb_reg_status (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic [`SB_REG_W-1:0]   rs1,
    input  logic [`SB_REG_W-1:0]   rs2,
    input  logic [`SB_REG_W-1:0]   rd,
    input  logic                   alloc_en,
    input  sb_pkg::fu_id_t         alloc_fu,
    input  logic [`SB_REG_W-1:0]   alloc_rd,
    input  logic [`SB_NUM_FU-1:0]  fu_done,
    output sb_pkg::tag_t           rs1_tag,
    output sb_pkg::tag_t           rs2_tag,
    output sb_pkg::tag_t           rd_tag
);

    // one pending-writer tag per architectural register
    sb_pkg::tag_t status [`SB_NUM_REGS];

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            for (int r = 0; r < `SB_NUM_REGS; r++) begin
                status[r] <= sb_pkg::TAG_NONE;
            end
        end else begin
            // x0 is hardwired, its entry keeps the reset value
            for (int r = 1; r < `SB_NUM_REGS; r++) begin
                if (alloc_en && alloc_rd == `SB_REG_W'(r)) begin
                    status[r].valid <= 1'b1;
                    status[r].fu    <= alloc_fu;
                end else if (status[r].valid && fu_done[status[r].fu]) begin
                    // only the unit still named here may release it
                    status[r].valid <= 1'b0;
                end
            end
        end
    end

    // lookups for the instruction sitting at fetch
    assign rs1_tag = status[rs1];
    assign rs2_tag = status[rs2];
    assign rd_tag  = status[rd];

    // dispatch must have held off a WAW before allocating
    a_no_double_owner: assert property (
        @(posedge CLK) disable iff (!rst_n)
        (alloc_en && alloc_rd != '0) |-> !status[alloc_rd].valid
    ) else $error("register %0d allocated while still pending", alloc_rd);

endmodule

// File: rtl/sb_pkg.sv
package sb_pkg;

    // instruction class as decoded by fetch
    typedef enum logic [1:0] {
        KIND_ALU  = 2'd0,
        KIND_LSU  = 2'd1,
        KIND_BR   = 2'd2,
        KIND_HALT = 2'd3
    } fu_kind_t;

    // functional unit index
    typedef logic [1:0] fu_id_t;

    localparam fu_id_t FU_ALU = 2'd0;
    localparam fu_id_t FU_LSU = 2'd1;
    localparam fu_id_t FU_BR  = 2'd2;

    // valid means the value is still owed by unit fu
    typedef struct packed {
        logic   valid;
        fu_id_t fu;
    } tag_t;

    localparam tag_t TAG_NONE = '0;

    // HALT has no unit of its own, it falls back to the ALU id
    function automatic fu_id_t kind_to_fu(input fu_kind_t kind);
        fu_id_t id;
        case (kind)
            KIND_LSU: id = FU_LSU;
            KIND_BR:  id = FU_BR;
            default:  id = FU_ALU;
        endcase
        return id;
    endfunction

endpackage

// File: rtl/sb_cfg.svh
`ifndef SB_CFG_SVH
`define SB_CFG_SVH

// architectural register file size
`define SB_NUM_REGS 32

// bits needed to name one register
`define SB_REG_W 5

// one unit per kind, ALU then LSU then BR
`define SB_NUM_FU 3

`endif
